//--- common/cmd_link_pkg.sv
// Command link package: lane word, host command, event and frame constants
`default_nettype none

package cmd_link_pkg;

   // ----------------------------------------------------------------------
   // Stream payloads
   // ----------------------------------------------------------------------

   // One transceiver lane word
   typedef struct packed {
      logic [15:0] data;
      logic [1:0]  ctrl;     // 00 data, 01 comma
   } lnk_word_t;

   // Host command into the framer
   typedef struct packed {
      logic [15:0] opcode;
      logic [15:0] param;
   } cmd_req_t;

   // Decoded command out of the parser
   typedef struct packed {
      logic [1:0]  cmd_type;
      logic [15:0] param;
   } cmd_evt_t;

   // ----------------------------------------------------------------------
   // Sizes
   // ----------------------------------------------------------------------

   // Entries in the receive elastic buffer
   localparam int LNK_FIFO_DEPTH = 8;

   // ----------------------------------------------------------------------
   // Frame constants
   // ----------------------------------------------------------------------

   // Idle/delimiter word, sent with comma ctrl code
   localparam logic [15:0] COMMA_WORD = 16'h02BC;
   // Start marker pair
   localparam logic [15:0] SOF_WORD0  = 16'h2410;
   localparam logic [15:0] SOF_WORD1  = 16'h1984;
   // End marker pair
   localparam logic [15:0] EOF_WORD0  = 16'hDBEF;
   localparam logic [15:0] EOF_WORD1  = 16'hE67B;

   // Ctrl codes
   localparam logic [1:0]  CTRL_DATA  = 2'b00;
   localparam logic [1:0]  CTRL_COMMA = 2'b01;

   // Parameter values with a dedicated command type
   localparam logic [15:0] PARAM_TYPE0 = 16'h0000;
   localparam logic [15:0] PARAM_TYPE1 = 16'h0001;
   localparam logic [15:0] PARAM_TYPE2 = 16'hAAAA;

   // Only this opcode carries a command
   localparam logic [15:0] CMD_OPCODE = 16'h0000;

endpackage

`default_nettype wire

//--- cmd_frame/cmd_frame_tx.sv
// Command framer: turns one host command into a nine-word lane frame
`timescale 1ns/1ps
`default_nettype none

module cmd_frame_tx (
   input  logic                    clk,
   input  logic                    rst_n,
   // Host command stream
   input  logic                    cmd_valid,
   output logic                    cmd_ready,
   input  cmd_link_pkg::cmd_req_t  cmd,
   // Lane word stream
   output logic                    link_out_valid,
   input  logic                    link_out_ready,
   output cmd_link_pkg::lnk_word_t link_out
);
   import cmd_link_pkg::*;

   // Frame in progress
   logic        busy;
   // Word position 0..8 inside the frame
   logic [3:0]  word_idx;
   // Captured command and its checksum
   logic [15:0] opcode_q;
   logic [15:0] param_q;
   logic [15:0] csum_q;
   logic        cmd_take;
   logic        word_take;

   assign cmd_take  = cmd_valid && cmd_ready;
   assign word_take = link_out_valid && link_out_ready;

   // Words are offered for as long as a frame is open
   assign link_out_valid = busy;

   // ----------------------------------------------------------------------
   // Control
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy      <= 1'b0;
         cmd_ready <= 1'b0;
         word_idx  <= 4'd0;
      end
      else if (cmd_take)
      begin
         busy      <= 1'b1;
         cmd_ready <= 1'b0;
         word_idx  <= 4'd0;
      end
      else if (word_take)
      begin
         // Last word is the closing comma
         if (word_idx == 4'd8)
         begin
            busy      <= 1'b0;
            cmd_ready <= 1'b1;
         end
         else
            word_idx <= word_idx + 4'd1;
      end
      else if (!busy)
         cmd_ready <= 1'b1;   // first idle cycle out of reset
   end

   // Command capture, sum of opcode and parameter mod 2^16
   always_ff @(posedge clk)
   begin
      if (cmd_take)
      begin
         opcode_q <= cmd.opcode;
         param_q  <= cmd.param;
         csum_q   <= cmd.opcode + cmd.param;
      end
   end

   // ----------------------------------------------------------------------
   // Word select
   // ----------------------------------------------------------------------
   always_comb
   begin
      link_out.ctrl = CTRL_DATA;
      case (word_idx)
         4'd0:    link_out.data = COMMA_WORD;
         4'd1:    link_out.data = SOF_WORD0;
         4'd2:    link_out.data = SOF_WORD1;
         4'd3:    link_out.data = opcode_q;
         4'd4:    link_out.data = param_q;
         4'd5:    link_out.data = csum_q;
         4'd6:    link_out.data = EOF_WORD0;
         4'd7:    link_out.data = EOF_WORD1;
         default: link_out.data = COMMA_WORD;
      endcase
      // Both frame ends are commas
      if (word_idx == 4'd0 || word_idx == 4'd8)
         link_out.ctrl = CTRL_COMMA;
   end

endmodule

`default_nettype wire

//--- cmd_frame/cmd_frame_rx.sv
// Frame parser: hunts for frames, checks checksum and trailer, decodes commands
`timescale 1ns/1ps
`default_nettype none

module cmd_frame_rx (
   input  logic                    clk,
   input  logic                    rst_n,
   // Lane words from the buffer
   input  logic                    in_valid,
   output logic                    in_ready,
   input  cmd_link_pkg::lnk_word_t in_word,
   // Decoded commands
   output logic                    cmd_valid,
   input  logic                    cmd_ready,
   output cmd_link_pkg::cmd_evt_t  cmd_evt,
   // Bad checksum or trailer
   output logic                    frame_err
);
   import cmd_link_pkg::*;

   typedef enum logic {ST_HUNT, ST_BODY} rx_state_t;

   rx_state_t   state;
   // Last two accepted words, hist1 the newer
   lnk_word_t   hist1;
   lnk_word_t   hist2;
   // Body word 0..5 after the start markers
   logic [2:0]  body_cnt;
   // Any body word so far out of place
   logic        bad_q;
   logic [15:0] opcode_q;
   logic [15:0] param_q;
   logic [15:0] csum_q;
   logic        take;
   logic        sof_seen;
   logic        word_bad;
   logic        close_now;
   logic        frame_ok;
   logic [15:0] csum_calc;
   logic [1:0]  type_dec;

   // Stall the buffer while an event waits
   assign in_ready = !cmd_valid;
   assign take     = in_valid && in_ready;

   // Comma, 2410, 1984 over three accepted words
   assign sof_seen = (hist2.ctrl == CTRL_COMMA) && (hist2.data == COMMA_WORD) &&
                     (hist1.ctrl == CTRL_DATA)  && (hist1.data == SOF_WORD0)  &&
                     (in_word.ctrl == CTRL_DATA) && (in_word.data == SOF_WORD1);

   // ----------------------------------------------------------------------
   // Body word checks
   // ----------------------------------------------------------------------
   always_comb
   begin
      case (body_cnt)
         3'd0, 3'd1, 3'd2: word_bad = (in_word.ctrl != CTRL_DATA);
         3'd3:    word_bad = (in_word.data != EOF_WORD0) || (in_word.ctrl != CTRL_DATA);
         3'd4:    word_bad = (in_word.data != EOF_WORD1) || (in_word.ctrl != CTRL_DATA);
         default: word_bad = (in_word.data != COMMA_WORD) || (in_word.ctrl != CTRL_COMMA);
      endcase
   end

   assign close_now = take && (state == ST_BODY) && (body_cnt == 3'd5);
   assign csum_calc = opcode_q + param_q;
   assign frame_ok  = !bad_q && !word_bad && (csum_calc == csum_q);

   // Command type from parameter
   always_comb
   begin
      case (param_q)
         PARAM_TYPE0: type_dec = 2'd0;
         PARAM_TYPE1: type_dec = 2'd1;
         PARAM_TYPE2: type_dec = 2'd2;
         default:     type_dec = 2'd3;
      endcase
   end

   // ----------------------------------------------------------------------
   // Word history, shifts on every accepted word
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hist1 <= '0;
         hist2 <= '0;
      end
      else if (take)
      begin
         hist2 <= hist1;
         hist1 <= in_word;   // closing comma can open the next frame
      end
   end

   // ----------------------------------------------------------------------
   // Frame FSM and outputs
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= ST_HUNT;
         body_cnt  <= 3'd0;
         bad_q     <= 1'b0;
         cmd_valid <= 1'b0;
         frame_err <= 1'b0;
      end
      else
      begin
         // Single-cycle pulse
         frame_err <= 1'b0;
         if (cmd_valid && cmd_ready)
            cmd_valid <= 1'b0;
         if (take)
         begin
            case (state)
               ST_HUNT:
               begin
                  if (sof_seen)
                  begin
                     state    <= ST_BODY;
                     body_cnt <= 3'd0;
                     bad_q    <= 1'b0;
                  end
               end
               default:
               begin
                  bad_q <= bad_q | word_bad;
                  if (body_cnt == 3'd5)
                  begin
                     state <= ST_HUNT;
                     if (!frame_ok)
                        frame_err <= 1'b1;
                     else if (opcode_q == CMD_OPCODE)
                        cmd_valid <= 1'b1;
                     // Other opcodes dropped without notice
                  end
                  else
                     body_cnt <= body_cnt + 3'd1;
               end
            endcase
         end
      end
   end

   // Payload latches
   always_ff @(posedge clk)
   begin
      if (take && (state == ST_BODY))
      begin
         case (body_cnt)
            3'd0:    opcode_q <= in_word.data;
            3'd1:    param_q  <= in_word.data;
            3'd2:    csum_q   <= in_word.data;
            default: ;
         endcase
      end
      if (close_now)
      begin
         cmd_evt.cmd_type <= type_dec;
         cmd_evt.param    <= param_q;
      end
   end

endmodule

`default_nettype wire

//--- verilog/lnk_word_fifo.sv
// Lane word elastic buffer between the link input and the frame parser
`timescale 1ns/1ps
`default_nettype none

module lnk_word_fifo (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_valid,
   output logic                    in_ready,
   input  cmd_link_pkg::lnk_word_t in_word,
   output logic                    out_valid,
   input  logic                    out_ready,
   output cmd_link_pkg::lnk_word_t out_word
);
   import cmd_link_pkg::*;

   // Word storage
   lnk_word_t                              mem [LNK_FIFO_DEPTH];
   logic [$clog2(LNK_FIFO_DEPTH)-1:0]      wr_ptr;
   logic [$clog2(LNK_FIFO_DEPTH)-1:0]      rd_ptr;
   // Occupancy 0..depth
   logic [$clog2(LNK_FIFO_DEPTH + 1)-1:0]  count;
   logic                                   full;
   logic                                   wr_en;
   logic                                   rd_en;

   assign full      = (count == LNK_FIFO_DEPTH);
   assign out_valid = (count != '0);
   // Full buffer still takes a word when one leaves
   assign in_ready  = !full || out_ready;
   assign wr_en     = in_valid && in_ready;
   assign rd_en     = out_valid && out_ready;
   assign out_word  = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= in_word;
   end

   // Pointers and occupancy
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == LNK_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == LNK_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;   // both or neither, level unchanged
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/cmd_link_top.sv
// Command link endpoint: transmit framer beside a buffered receive parser
`timescale 1ns/1ps
`default_nettype none

module cmd_link_top (
   input  logic                    clk,
   input  logic                    rst_n,
   // Host commands to frame
   input  logic                    cmd_req_valid,
   output logic                    cmd_req_ready,
   input  cmd_link_pkg::cmd_req_t  cmd_req,
   // Lane transmit words
   output logic                    link_out_valid,
   input  logic                    link_out_ready,
   output cmd_link_pkg::lnk_word_t link_out,
   // Lane receive words
   input  logic                    link_in_valid,
   output logic                    link_in_ready,
   input  cmd_link_pkg::lnk_word_t link_in,
   // Decoded commands and frame errors
   output logic                    cmd_valid,
   input  logic                    cmd_ready,
   output cmd_link_pkg::cmd_evt_t  cmd_evt,
   output logic                    frame_err
);
   import cmd_link_pkg::*;

   // Buffer to parser stream
   logic      fifo_valid;
   logic      fifo_ready;
   lnk_word_t fifo_word;

   // ----------------------------------------------------------------------
   // Transmit side
   // ----------------------------------------------------------------------
   cmd_frame_tx u_tx (
      .clk            (clk),
      .rst_n          (rst_n),
      .cmd_valid      (cmd_req_valid),
      .cmd_ready      (cmd_req_ready),
      .cmd            (cmd_req),
      .link_out_valid (link_out_valid),
      .link_out_ready (link_out_ready),
      .link_out       (link_out)
   );

   // ----------------------------------------------------------------------
   // Receive side
   // ----------------------------------------------------------------------
   lnk_word_fifo u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (link_in_valid),
      .in_ready  (link_in_ready),
      .in_word   (link_in),
      .out_valid (fifo_valid),
      .out_ready (fifo_ready),
      .out_word  (fifo_word)
   );

   cmd_frame_rx u_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (fifo_valid),
      .in_ready  (fifo_ready),
      .in_word   (fifo_word),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_evt   (cmd_evt),
      .frame_err (frame_err)
   );

endmodule

`default_nettype wire

//--- bench/cmd_link_assertions.sv
// Parser protocol assertions bound to the frame parser
`timescale 1ns/1ps
`default_nettype none

module cmd_link_assertions (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    in_valid,
   input cmd_link_pkg::lnk_word_t in_word,
   input logic                    cmd_valid,
   input logic                    cmd_ready,
   input cmd_link_pkg::cmd_evt_t  cmd_evt,
   input logic                    frame_err
);

   // ----------------------------------------------------------------------
   // Event stream
   // ----------------------------------------------------------------------

   // Pending event holds until taken
   a_evt_held: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_evt))
      else $error("cmd_valid or cmd_evt changed before cmd_ready");

   // Buffer head word stays in place while an event waits
   a_stall: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && in_valid |=> in_valid && $stable(in_word))
      else $error("parser consumed a word while an event was pending");

   // ----------------------------------------------------------------------
   // Error pulse
   // ----------------------------------------------------------------------
   a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
      !(frame_err && cmd_valid))
      else $error("frame_err raised together with cmd_valid");

   a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      frame_err |=> !frame_err)
      else $error("frame_err lasted more than one cycle");

endmodule

bind cmd_frame_rx cmd_link_assertions u_assertions (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .in_word   (in_word),
   .cmd_valid (cmd_valid),
   .cmd_ready (cmd_ready),
   .cmd_evt   (cmd_evt),
   .frame_err (frame_err)
);

`default_nettype wire

//--- bench/tb_cmd_link.sv
// Command link testbench with random loopback and corruption against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_link;
   import cmd_link_pkg::*;

   localparam int NUM_CMDS    = 80;
   localparam int WAIT_LIMIT  = 2000;
   localparam int DRAIN_LIMIT = 40000;

   // One command as sent with its planned corruption
   typedef struct packed {
      logic [15:0] opcode;
      logic [15:0] param;
      logic        corrupt;
      logic [1:0]  word_sel;   // 0 opcode, 1 param, 2 checksum
      logic [3:0]  bit_pos;
   } frame_t;

   // Predicted parser outcome
   typedef struct packed {
      logic        is_err;
      logic [1:0]  cmd_type;
      logic [15:0] param;
   } exp_t;

   logic clk;
   logic rst_n;
   logic cmd_req_valid;
   logic cmd_req_ready;
   cmd_req_t  cmd_req;
   logic link_out_valid;
   logic link_out_ready;
   lnk_word_t link_out;
   logic link_in_valid;
   logic link_in_ready;
   lnk_word_t link_in;
   logic cmd_valid;
   logic cmd_ready;
   cmd_evt_t  cmd_evt;
   logic frame_err;

   // Testbench state
   logic [31:0] lfsr;
   logic        run_en;
   logic        cmd_taken;
   logic        in_taken;
   int          issued;
   int          accepted;
   int          tx_idx;
   int          req_wait;
   int          in_wait;
   int          mon_cycles;
   frame_t      drv_frame;
   frame_t      cur_frame;
   frame_t      frame_q[$];
   lnk_word_t   loop_q[$];
   exp_t        exp_q[$];

   cmd_link_top UUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .cmd_req_valid  (cmd_req_valid),
      .cmd_req_ready  (cmd_req_ready),
      .cmd_req        (cmd_req),
      .link_out_valid (link_out_valid),
      .link_out_ready (link_out_ready),
      .link_out       (link_out),
      .link_in_valid  (link_in_valid),
      .link_in_ready  (link_in_ready),
      .link_in        (link_in),
      .cmd_valid      (cmd_valid),
      .cmd_ready      (cmd_ready),
      .cmd_evt        (cmd_evt),
      .frame_err      (frame_err)
   );

   always #5 clk = ~clk;

   // ----------------------------------------------------------------------
   // Random source with taps 32 22 2 1
   // ----------------------------------------------------------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------

   // Expected word at position idx of a frame
   function automatic lnk_word_t frame_word(input int idx, input frame_t f);
      lnk_word_t w;
      w.ctrl = 2'b00;
      case (idx)
         1:       w.data = 16'h2410;
         2:       w.data = 16'h1984;
         3:       w.data = f.opcode;
         4:       w.data = f.param;
         5:       w.data = f.opcode + f.param;
         6:       w.data = 16'hDBEF;
         7:       w.data = 16'hE67B;
         default: w.data = 16'h02BC;
      endcase
      // Frame opens and closes with a comma
      if (idx == 0 || idx == 8)
         w.ctrl = 2'b01;
      return w;
   endfunction

   function automatic exp_t expect_outcome(input frame_t f);
      exp_t e;
      e = '0;
      if (f.corrupt)
         e.is_err = 1'b1;
      else
      begin
         e.param = f.param;
         case (f.param)
            16'h0000: e.cmd_type = 2'd0;
            16'h0001: e.cmd_type = 2'd1;
            16'hAAAA: e.cmd_type = 2'd2;
            default:  e.cmd_type = 2'd3;
         endcase
      end
      return e;
   endfunction

   // Everything sent has been looped back and resolved
   function automatic logic all_drained();
      return (accepted == NUM_CMDS) && (frame_q.size() == 0) && (tx_idx == 0) &&
             (loop_q.size() == 0) && !link_in_valid && (exp_q.size() == 0);
   endfunction

   // ----------------------------------------------------------------------
   // Error reporting
   // ----------------------------------------------------------------------
   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp)
         stop_on_error($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   // ----------------------------------------------------------------------
   // Stimulus on the falling edge
   // ----------------------------------------------------------------------
   task automatic present_command();
      logic [15:0] r;
      r = take_bits(2);
      // Opcode 0000 three times in four
      drv_frame.opcode = (r[1:0] != 2'd0) ? 16'h0000 : take_bits(16);
      r = take_bits(2);
      case (r[1:0])
         2'd0:    drv_frame.param = 16'h0000;
         2'd1:    drv_frame.param = 16'h0001;
         2'd2:    drv_frame.param = 16'hAAAA;
         default: drv_frame.param = take_bits(16);
      endcase
      r = take_bits(2);
      drv_frame.corrupt = (r[1:0] == 2'd0);
      r = take_bits(2);
      // Corruption only in payload words
      drv_frame.word_sel = (r[1:0] == 2'd3) ? 2'd0 : r[1:0];
      r = take_bits(4);
      drv_frame.bit_pos = r[3:0];
      cmd_req = {drv_frame.opcode, drv_frame.param};
      cmd_req_valid = 1'b1;
      issued++;
   endtask

   always @(negedge clk)
   begin
      logic [15:0] r;
      if (run_en)
      begin
         // Drop valids that transferred at the last edge
         if (cmd_taken)
         begin
            cmd_req_valid = 1'b0;
            cmd_taken = 1'b0;
         end
         if (in_taken)
         begin
            link_in_valid = 1'b0;
            in_taken = 1'b0;
         end
         r = take_bits(2);
         if (!cmd_req_valid && issued < NUM_CMDS && r[1:0] == 2'd0)
            present_command();
         r = take_bits(2);
         if (!link_in_valid && loop_q.size() > 0 && r[1:0] != 2'd0)
         begin
            link_in = loop_q[0];
            link_in_valid = 1'b1;
         end
         r = take_bits(2);
         link_out_ready = (r[1:0] != 2'd0);
         r = take_bits(1);
         cmd_ready = r[0];
      end
   end

   // ----------------------------------------------------------------------
   // Monitor and checks on the rising edge
   // ----------------------------------------------------------------------
   always @(posedge clk)
   begin
      lnk_word_t sent_word;
      exp_t      e;
      logic      tx_idle;
      if (rst_n && run_en)
      begin
         // Framer offers words only inside a frame
         tx_idle = (frame_q.size() == 0) && (tx_idx == 0);
         check_value(link_out_valid, !tx_idle, "link_out_valid");
         // Ready only while idle and low in the first cycle after reset
         check_value(cmd_req_ready, tx_idle && (mon_cycles > 0), "cmd_req_ready");
         mon_cycles++;
         // Predict the outcome of each accepted command
         if (cmd_req_valid && cmd_req_ready)
         begin
            cmd_taken = 1'b1;
            accepted++;
            frame_q.push_back(drv_frame);
            if (drv_frame.corrupt || drv_frame.opcode == 16'h0000)
               exp_q.push_back(expect_outcome(drv_frame));
         end
         // Framer words are checked then looped back
         if (link_out_valid && link_out_ready)
         begin
            if (tx_idx == 0)
            begin
               if (frame_q.size() == 0)
                  stop_on_error("Framer sent a word with no command outstanding");
               cur_frame = frame_q.pop_front();
            end
            check_value(link_out, frame_word(tx_idx, cur_frame),
                        $sformatf("link_out word %0d", tx_idx));
            sent_word = link_out;
            if (cur_frame.corrupt && tx_idx == 3 + cur_frame.word_sel)
               sent_word.data[cur_frame.bit_pos] = ~sent_word.data[cur_frame.bit_pos];
            loop_q.push_back(sent_word);
            tx_idx = (tx_idx == 8) ? 0 : tx_idx + 1;
         end
         if (link_in_valid && link_in_ready)
         begin
            void'(loop_q.pop_front());
            in_taken = 1'b1;
         end
         // Parser outcomes in order
         if (frame_err)
         begin
            if (exp_q.size() == 0)
               stop_on_error("frame_err pulsed with no frame outcome outstanding");
            e = exp_q.pop_front();
            check_value(1, e.is_err, "frame_err where a command was due");
         end
         if (cmd_valid && cmd_ready)
         begin
            if (exp_q.size() == 0)
               stop_on_error("Command event arrived with no frame outcome outstanding");
            e = exp_q.pop_front();
            check_value(0, e.is_err, "command event where frame_err was due");
            check_value(cmd_evt.cmd_type, e.cmd_type, "cmd_evt type");
            check_value(cmd_evt.param, e.param, "cmd_evt param");
         end
         // Handshake stall watchdogs
         req_wait = (cmd_req_valid && !cmd_req_ready) ? req_wait + 1 : 0;
         in_wait  = (link_in_valid && !link_in_ready) ? in_wait + 1 : 0;
         if (req_wait > WAIT_LIMIT)
            stop_on_error("Timed out waiting for the framer to accept a command");
         if (in_wait > WAIT_LIMIT)
            stop_on_error("Timed out waiting for the buffer to accept a link word");
      end
   end

   // ----------------------------------------------------------------------
   // Reset and end of run
   // ----------------------------------------------------------------------
   initial
   begin
      int cycles;
      lfsr = 32'h2240_d9ae;
      clk = 1'b0;
      rst_n = 1'b0;
      run_en = 1'b0;
      cmd_taken = 1'b0;
      in_taken = 1'b0;
      issued = 0;
      accepted = 0;
      tx_idx = 0;
      req_wait = 0;
      in_wait = 0;
      mon_cycles = 0;
      drv_frame = '0;
      cur_frame = '0;
      cmd_req_valid = 1'b0;
      cmd_req = '0;
      link_out_ready = 1'b0;
      link_in_valid = 1'b0;
      link_in = '0;
      cmd_ready = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      run_en = 1'b1;
      cycles = 0;
      while (!all_drained() && cycles < DRAIN_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (all_drained())
      begin
         // Quiet period catches late spurious outcomes
         repeat (40) @(negedge clk);
         $display("TEST RESULT: PASS");
         $finish;
      end
      else
         stop_on_error("Timed out waiting for all frames to pass through the link");
   end

endmodule

`default_nettype wire

//--- filelist.f
common/cmd_link_pkg.sv
cmd_frame/cmd_frame_tx.sv
cmd_frame/cmd_frame_rx.sv
verilog/lnk_word_fifo.sv
verilog/cmd_link_top.sv
bench/cmd_link_assertions.sv
bench/tb_cmd_link.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the command link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_cmd_link -f filelist.f -o sim_tb_cmd_link
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb_cmd_link > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

echo "Simulation finished without failure"
exit 0
